//--- build.f
rtl/ntp_auth_pkg.sv
rtl/udp_payload_aligner.sv
rtl/ntp_field_capture.sv
rtl/key_fetch.sv
rtl/md5_block_builder.sv
rtl/md5_auth_control.sv
rtl/ntp_auth.sv
testbench/tb_ntp_auth.sv

//--- Bender.yml
package:
  name: ntp_auth

sources:
  - rtl/ntp_auth_pkg.sv
  - rtl/udp_payload_aligner.sv
  - rtl/ntp_field_capture.sv
  - rtl/key_fetch.sv
  - rtl/md5_block_builder.sv
  - rtl/md5_auth_control.sv
  - rtl/ntp_auth.sv
  - target: test
    files:
      - testbench/tb_ntp_auth.sv

//--- testbench/tb_ntp_auth.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ntp_auth
  import ntp_auth_pkg::*;
();

  localparam int FRAME_WORDS = 14;
  localparam int TIMEOUT = 200;

  logic i_clk;
  logic i_areset;
  logic i_auth_md5;
  logic i_rx_reset;
  logic i_rx_valid;
  logic [RX_WORD_W-1:0] i_rx_data;
  logic [KEY_WORD_IDX_W-1:0] i_keymem_key_word;
  logic i_keymem_key_valid;
  logic [31:0] i_keymem_key_data;
  logic i_keymem_ready;
  logic i_md5_ready;
  logic [MAC_W-1:0] i_md5_digest;
  logic o_auth_md5_ready;
  logic o_auth_md5_good;
  logic o_keymem_get_key_md5;
  logic [31:0] o_keymem_keyid;
  logic o_md5_init;
  logic o_md5_next;
  logic [MD5_BLOCK_W-1:0] o_md5_block;

  logic [31:0] lfsr_state;
  logic [7:0] frame_bytes [0:FRAME_WORDS*8-1];
  logic [31:0] key_words [0:KEY_WORDS-1];
  logic [KEY_WORD_IDX_W-1:0] key_order [0:KEY_WORDS-1];
  logic [31:0] exp_keyid;
  logic [MAC_W-1:0] exp_mac;
  logic [MD5_BLOCK_W-1:0] exp_block1;
  logic [MD5_BLOCK_W-1:0] exp_block2;
  logic exp_good;
  int exp_init_cnt;
  int exp_next_cnt;
  logic kmem_short;
  int kmem_sent;
  logic [MAC_W-1:0] stub_digest;
  logic [2:0] stub_wait;
  int get_cnt;
  int init_cnt;
  int next_cnt;
  int error_count;
  int timeout_count;

  ntp_auth i_ntp_auth (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [MD5_BLOCK_W-1:0] expected,
                                 input logic [MD5_BLOCK_W-1:0] actual);
    error_count++;
    $display("FAILED time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
  endtask

  task automatic finish_run();
    $display("Errors: %0d check failures, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  // ------------------------------------------------------------
  // Expected MD5 blocks from the message bytes
  // ------------------------------------------------------------
  task automatic compute_expected();
    logic [7:0] m1 [0:63];
    logic [7:0] m2 [0:63];
    // Key word 4 leads the message, header follows from payload byte 0
    for (int i = 0; i < 20; i++) begin
      m1[i] = key_words[KEY_WORDS-1 - i/4][31 - 8*(i%4) -: 8];
    end
    for (int i = 0; i < 44; i++) begin
      m1[20+i] = frame_bytes[42+i];
    end
    for (int i = 0; i < 64; i++) begin
      m2[i] = 8'h00;
    end
    for (int i = 0; i < 4; i++) begin
      m2[i] = frame_bytes[86+i];
    end
    m2[4] = 8'h80;
    // 544 bit message length, little-endian
    m2[56] = 8'h20;
    m2[57] = 8'h02;
    for (int w = 0; w < 16; w++) begin
      exp_block1[511-32*w -: 32] = {m1[4*w+3], m1[4*w+2], m1[4*w+1], m1[4*w]};
      exp_block2[511-32*w -: 32] = {m2[4*w+3], m2[4*w+2], m2[4*w+1], m2[4*w]};
    end
  endtask

  // Payload starts at frame byte 42, key id sits at 90 and MAC at 94
  task automatic build_frame(input logic ipv4);
    mac_word_u mw;
    logic [MAC_W-1:0] mac;
    for (int i = 0; i < FRAME_WORDS*8; i++) begin
      frame_bytes[i] = 8'(random_bits(8));
    end
    frame_bytes[12] = ipv4 ? 8'h08 : 8'h86;
    frame_bytes[13] = ipv4 ? 8'h00 : 8'hdd;
    if (ipv4) begin
      mac = {random_bits(32), random_bits(32), random_bits(32), random_bits(32)};
      mw.half[1] = random_bits(32);
      mw.half[0] = mac[127:96];
      for (int b = 0; b < 8; b++) begin
        frame_bytes[90+b] = mw.raw[63-8*b -: 8];
      end
      for (int b = 0; b < 12; b++) begin
        frame_bytes[98+b] = mac[95-8*b -: 8];
      end
      exp_keyid = mw.half[1];
      exp_mac = mac;
      for (int k = 0; k < KEY_WORDS; k++) begin
        key_words[k] = random_bits(32);
      end
      compute_expected();
    end
  endtask

  task automatic send_frame();
    logic [RX_WORD_W-1:0] w;
    @(posedge i_clk);
    i_rx_reset <= 1'b1;
    @(posedge i_clk);
    i_rx_reset <= 1'b0;
    for (int n = 0; n < FRAME_WORDS; n++) begin
      for (int b = 0; b < 8; b++) begin
        w[63-8*b -: 8] = frame_bytes[8*n+b];
      end
      @(posedge i_clk);
      i_rx_valid <= 1'b1;
      i_rx_data <= w;
    end
    @(posedge i_clk);
    i_rx_valid <= 1'b0;
    i_rx_data <= '0;
    // Flush word follows the gap, capture takes it one cycle later
    repeat (3) @(posedge i_clk);
  endtask

  task automatic wait_ready(input logic level);
    int cycles;
    cycles = 0;
    while (o_auth_md5_ready !== level && cycles < TIMEOUT) begin
      @(posedge i_clk);
      cycles++;
    end
    if (o_auth_md5_ready !== level) begin
      $display("ERROR: o_auth_md5_ready did not reach %0b within %0d cycles", level, TIMEOUT);
      timeout_count++;
      finish_run();
    end
  endtask

  task automatic run_auth(input logic [MAC_W-1:0] digest, input logic good,
                          input logic short_key);
    stub_digest = digest;
    exp_good = good;
    kmem_short = short_key;
    exp_init_cnt = short_key ? 0 : 1;
    exp_next_cnt = short_key ? 0 : 2;
    wait_ready(1'b1);
    i_auth_md5 <= 1'b1;
    @(posedge i_clk);
    i_auth_md5 <= 1'b0;
    wait_ready(1'b0);
    wait_ready(1'b1);
  endtask

  task automatic shuffle_key_order();
    int j;
    logic [KEY_WORD_IDX_W-1:0] t;
    for (int i = 0; i < KEY_WORDS; i++) begin
      key_order[i] = KEY_WORD_IDX_W'(i);
    end
    for (int i = KEY_WORDS - 1; i > 0; i--) begin
      j = int'(random_bits(3)) % (i + 1);
      t = key_order[i];
      key_order[i] = key_order[j];
      key_order[j] = t;
    end
  endtask

  // ------------------------------------------------------------
  // Key memory model and MD5 core stub
  // ------------------------------------------------------------
  always @(posedge i_clk) begin
    if (o_keymem_get_key_md5) begin
      shuffle_key_order();
      i_keymem_ready <= 1'b0;
      i_keymem_key_valid <= 1'b1;
      i_keymem_key_word <= key_order[0];
      i_keymem_key_data <= key_words[key_order[0]];
      kmem_sent <= 1;
    end else if (i_keymem_key_valid) begin
      if (kmem_sent == (kmem_short ? 3 : KEY_WORDS)) begin
        i_keymem_key_valid <= 1'b0;
        i_keymem_ready <= 1'b1;
      end else begin
        i_keymem_key_word <= key_order[kmem_sent];
        i_keymem_key_data <= key_words[key_order[kmem_sent]];
        kmem_sent <= kmem_sent + 1;
      end
    end
  end

  always @(posedge i_clk) begin
    if (o_md5_init || o_md5_next) begin
      i_md5_ready <= 1'b0;
      stub_wait <= 3'(random_bits(2)) + 3'd1;
    end else if (!i_md5_ready) begin
      if (stub_wait == 3'd1) begin
        i_md5_ready <= 1'b1;
        i_md5_digest <= stub_digest;
      end else begin
        stub_wait <= stub_wait - 3'd1;
      end
    end
  end

  // Pulse counts per authentication run
  always @(posedge i_clk) begin
    if (i_auth_md5) begin
      get_cnt <= 0;
      init_cnt <= 0;
      next_cnt <= 0;
    end else begin
      if (o_keymem_get_key_md5) get_cnt <= get_cnt + 1;
      if (o_md5_init) init_cnt <= init_cnt + 1;
      if (o_md5_next) next_cnt <= next_cnt + 1;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  a_reset_outputs : assert property (@(posedge i_clk) $fell(i_areset) |->
    {o_auth_md5_ready, o_auth_md5_good, o_keymem_get_key_md5, o_md5_init, o_md5_next} == 5'b10000)
    else report_mismatch("{ready,good,get_key,init,next}", 5'b10000, $sampled(
      {o_auth_md5_ready, o_auth_md5_good, o_keymem_get_key_md5, o_md5_init, o_md5_next}));

  a_single_request : assert property (@(posedge i_clk) disable iff (i_areset)
    o_keymem_get_key_md5 |-> get_cnt == 0)
    else report_mismatch("earlier o_keymem_get_key_md5 pulses", 0, $sampled(get_cnt));

  a_request_keyid : assert property (@(posedge i_clk) disable iff (i_areset)
    o_keymem_get_key_md5 |-> o_keymem_keyid == exp_keyid)
    else report_mismatch("o_keymem_keyid", $sampled(exp_keyid), $sampled(o_keymem_keyid));

  a_first_block : assert property (@(posedge i_clk) disable iff (i_areset)
    (o_md5_next && next_cnt == 0) |-> o_md5_block == exp_block1)
    else report_mismatch("o_md5_block (first)", $sampled(exp_block1), $sampled(o_md5_block));

  a_second_block : assert property (@(posedge i_clk) disable iff (i_areset)
    (o_md5_next && next_cnt == 1) |-> o_md5_block == exp_block2)
    else report_mismatch("o_md5_block (second)", $sampled(exp_block2), $sampled(o_md5_block));

  a_auth_good : assert property (@(posedge i_clk) disable iff (i_areset)
    $rose(o_auth_md5_ready) |-> o_auth_md5_good == exp_good)
    else report_mismatch("o_auth_md5_good", $sampled(exp_good), $sampled(o_auth_md5_good));

  a_request_count : assert property (@(posedge i_clk) disable iff (i_areset)
    $rose(o_auth_md5_ready) |-> get_cnt == 1)
    else report_mismatch("o_keymem_get_key_md5 pulses", 1, $sampled(get_cnt));

  a_init_count : assert property (@(posedge i_clk) disable iff (i_areset)
    $rose(o_auth_md5_ready) |-> init_cnt == exp_init_cnt)
    else report_mismatch("o_md5_init pulses", $sampled(exp_init_cnt), $sampled(init_cnt));

  a_next_count : assert property (@(posedge i_clk) disable iff (i_areset)
    $rose(o_auth_md5_ready) |-> next_cnt == exp_next_cnt)
    else report_mismatch("o_md5_next pulses", $sampled(exp_next_cnt), $sampled(next_cnt));

  initial begin
    lfsr_state = 32'ha1a028ea;
    i_areset = 1'b1;
    i_auth_md5 = 1'b0;
    i_rx_reset = 1'b0;
    i_rx_valid = 1'b0;
    i_rx_data = '0;
    i_keymem_key_word = '0;
    i_keymem_key_valid = 1'b0;
    i_keymem_key_data = '0;
    i_keymem_ready = 1'b1;
    i_md5_ready = 1'b1;
    i_md5_digest = '0;
    {get_cnt, init_cnt, next_cnt, kmem_sent} = '0;
    {error_count, timeout_count, exp_init_cnt, exp_next_cnt} = '0;
    {exp_keyid, exp_mac, exp_block1, exp_block2, exp_good} = '0;
    kmem_short = 1'b0;
    stub_digest = '0;
    stub_wait = '0;
    repeat (4) @(posedge i_clk);
    i_areset <= 1'b0;
    repeat (2) @(posedge i_clk);

    // Authentic frame, then the same frame against a digest with one bit flipped
    build_frame(1'b1);
    send_frame();
    run_auth(exp_mac, 1'b1, 1'b0);
    run_auth(exp_mac ^ (MAC_W'(1) << random_bits(7)), 1'b0, 1'b0);

    // Key memory goes idle after three words
    build_frame(1'b1);
    send_frame();
    run_auth(exp_mac, 1'b0, 1'b1);

    // Non-IPv4 frame leaves the fields of the previous frame in place
    build_frame(1'b0);
    send_frame();
    run_auth(exp_mac, 1'b1, 1'b0);

    repeat (2) @(posedge i_clk);
    finish_run();
  end

endmodule

`default_nettype wire

//--- rtl/ntp_auth.sv
`timescale 1ns/1ps
`default_nettype none

module ntp_auth
  import ntp_auth_pkg::*;
(
  input wire i_clk,
  input wire i_areset,
  input wire i_auth_md5,
  output logic o_auth_md5_ready,
  output logic o_auth_md5_good,
  input wire i_rx_reset,
  input wire i_rx_valid,
  input wire [RX_WORD_W-1:0] i_rx_data,
  output logic o_keymem_get_key_md5,
  output logic [31:0] o_keymem_keyid,
  input wire [KEY_WORD_IDX_W-1:0] i_keymem_key_word,
  input wire i_keymem_key_valid,
  input wire [31:0] i_keymem_key_data,
  input wire i_keymem_ready,
  output logic o_md5_init,
  output logic o_md5_next,
  output logic [MD5_BLOCK_W-1:0] o_md5_block,
  input wire i_md5_ready,
  input wire [MAC_W-1:0] i_md5_digest
);

  logic payload_valid;
  logic [RX_WORD_W-1:0] payload_data;
  logic [NTP_HEADER_WORDS*RX_WORD_W-1:0] ntp_header;
  logic [31:0] keyid;
  logic [MAC_W-1:0] mac;
  logic key_start;
  logic [KEY_WORDS*32-1:0] key;
  logic key_done;
  logic key_error;
  logic load_first;
  logic load_second;

  // Receive side
  udp_payload_aligner u_aligner (
    .i_clk(i_clk), .i_areset(i_areset), .i_rx_reset(i_rx_reset),
    .i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data),
    .o_payload_valid(payload_valid), .o_payload_data(payload_data)
  );

  ntp_field_capture u_capture (
    .i_clk(i_clk), .i_areset(i_areset), .i_rx_reset(i_rx_reset),
    .i_payload_valid(payload_valid), .i_payload_data(payload_data),
    .o_ntp_header(ntp_header), .o_keyid(keyid), .o_mac(mac)
  );

  // Authentication side
  key_fetch u_key_fetch (
    .i_clk(i_clk), .i_areset(i_areset), .i_start(key_start), .i_keyid(keyid),
    .i_keymem_ready(i_keymem_ready), .i_keymem_key_valid(i_keymem_key_valid),
    .i_keymem_key_word(i_keymem_key_word), .i_keymem_key_data(i_keymem_key_data),
    .o_keymem_get_key_md5(o_keymem_get_key_md5), .o_keymem_keyid(o_keymem_keyid),
    .o_key(key), .o_key_done(key_done), .o_key_error(key_error)
  );

  md5_block_builder u_block_builder (
    .i_clk(i_clk), .i_areset(i_areset), .i_load_first(load_first),
    .i_load_second(load_second), .i_key(key), .i_ntp_header(ntp_header),
    .o_block(o_md5_block)
  );

  md5_auth_control u_control (
    .i_clk(i_clk), .i_areset(i_areset), .i_auth_md5(i_auth_md5),
    .i_key_done(key_done), .i_key_error(key_error), .i_md5_ready(i_md5_ready),
    .i_md5_digest(i_md5_digest), .i_mac(mac),
    .o_auth_md5_ready(o_auth_md5_ready), .o_auth_md5_good(o_auth_md5_good),
    .o_key_start(key_start), .o_load_first(load_first), .o_load_second(load_second),
    .o_md5_init(o_md5_init), .o_md5_next(o_md5_next)
  );

endmodule

`default_nettype wire

//--- rtl/md5_auth_control.sv
`timescale 1ns/1ps
`default_nettype none

module md5_auth_control
  import ntp_auth_pkg::*;
(
  input wire i_clk,
  input wire i_areset,
  input wire i_auth_md5,
  input wire i_key_done,
  input wire i_key_error,
  input wire i_md5_ready,
  input wire [MAC_W-1:0] i_md5_digest,
  input wire [MAC_W-1:0] i_mac,
  output logic o_auth_md5_ready,
  output logic o_auth_md5_good,
  output logic o_key_start,
  output logic o_load_first,
  output logic o_load_second,
  output logic o_md5_init,
  output logic o_md5_next
);

  logic [AUTH_FSM_W-1:0] state;
  logic ready;
  logic good;
  logic busy_seen;
  logic in_wait;
  logic core_done;

  assign in_wait = (state == AUTH_INIT_WAIT) || (state == AUTH_NEXT0_WAIT) ||
                   (state == AUTH_NEXT1_WAIT);
  // Core has gone busy and come back
  assign core_done = in_wait && busy_seen && i_md5_ready;

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state <= AUTH_IDLE;
      ready <= 1'b1;
      good <= 1'b0;
      busy_seen <= 1'b0;
    end else begin
      if (in_wait && !i_md5_ready) begin
        busy_seen <= 1'b1;
      end else if (core_done) begin
        busy_seen <= 1'b0;
      end
      case (state)
        AUTH_IDLE: begin
          if (i_auth_md5) begin
            state <= AUTH_KEY_WAIT;
            ready <= 1'b0;
            good <= 1'b0;
          end
        end
        AUTH_KEY_WAIT: begin
          if (i_key_done) begin
            state <= AUTH_INIT;
          end else if (i_key_error) begin
            state <= AUTH_IDLE;
            ready <= 1'b1;
          end
        end
        AUTH_INIT: if (i_md5_ready) state <= AUTH_INIT_WAIT;
        AUTH_INIT_WAIT: if (core_done) state <= AUTH_NEXT0;
        AUTH_NEXT0: if (i_md5_ready) state <= AUTH_NEXT0_WAIT;
        AUTH_NEXT0_WAIT: if (core_done) state <= AUTH_NEXT1;
        AUTH_NEXT1: if (i_md5_ready) state <= AUTH_NEXT1_WAIT;
        AUTH_NEXT1_WAIT: begin
          if (core_done) begin
            state <= AUTH_IDLE;
            ready <= 1'b1;
            good <= (i_md5_digest == i_mac);
          end
        end
      endcase
    end
  end

  // Blocks are loaded on the edge before the core is told to use them
  assign o_key_start = (state == AUTH_IDLE) && i_auth_md5;
  assign o_load_first = (state == AUTH_KEY_WAIT) && i_key_done;
  assign o_load_second = (state == AUTH_NEXT0_WAIT) && core_done;
  assign o_md5_init = (state == AUTH_INIT) && i_md5_ready;
  assign o_md5_next = ((state == AUTH_NEXT0) || (state == AUTH_NEXT1)) && i_md5_ready;
  assign o_auth_md5_ready = ready;
  assign o_auth_md5_good = good;

  a_init_next_exclusive : assert property (
    @(posedge i_clk) disable iff (i_areset) !(o_md5_init && o_md5_next)
  );

endmodule

`default_nettype wire

//--- rtl/md5_block_builder.sv
`timescale 1ns/1ps
`default_nettype none

module md5_block_builder
  import ntp_auth_pkg::*;
(
  input wire i_clk,
  input wire i_areset,
  input wire i_load_first,
  input wire i_load_second,
  input wire [KEY_WORDS*32-1:0] i_key,
  input wire [NTP_HEADER_WORDS*RX_WORD_W-1:0] i_ntp_header,
  output logic [MD5_BLOCK_W-1:0] o_block
);

  logic [MD5_BLOCK_W-1:0] first_block;
  logic [MD5_BLOCK_W-1:0] padded_block;
  logic [MD5_BLOCK_W-1:0] block;

  // MD5 reads each 32-bit word little-endian
  function automatic logic [MD5_BLOCK_W-1:0] swap_words(input logic [MD5_BLOCK_W-1:0] d);
    logic [MD5_BLOCK_W-1:0] r;
    for (int w = 0; w < MD5_BLOCK_W / 32; w++) begin
      for (int b = 0; b < 4; b++) begin
        r[w*32 + b*8 +: 8] = d[w*32 + (3-b)*8 +: 8];
      end
    end
    return r;
  endfunction

  assign first_block = swap_words({i_key, i_ntp_header[NTP_HEADER_WORDS*RX_WORD_W-1:32]});
  assign padded_block = swap_words({i_ntp_header[31:0], MD5_PAD_BYTE,
                                    {(MD5_BLOCK_W - 40){1'b0}}});

  // Length field goes in as two words, low half first
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      block <= '0;
    end else if (i_load_first) begin
      block <= first_block;
    end else if (i_load_second) begin
      block <= {padded_block[MD5_BLOCK_W-1:64], MD5_MSG_BITS[31:0], MD5_MSG_BITS[63:32]};
    end
  end

  assign o_block = block;

  a_single_load : assert property (
    @(posedge i_clk) disable iff (i_areset) !(i_load_first && i_load_second)
  );

endmodule

`default_nettype wire

//--- rtl/key_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module key_fetch
  import ntp_auth_pkg::*;
(
  input wire i_clk,
  input wire i_areset,
  input wire i_start,
  input wire [31:0] i_keyid,
  input wire i_keymem_ready,
  input wire i_keymem_key_valid,
  input wire [KEY_WORD_IDX_W-1:0] i_keymem_key_word,
  input wire [31:0] i_keymem_key_data,
  output logic o_keymem_get_key_md5,
  output logic [31:0] o_keymem_keyid,
  output logic [KEY_WORDS*32-1:0] o_key,
  output logic o_key_done,
  output logic o_key_error
);

  logic [KEY_FSM_W-1:0] state;
  logic [KEY_WORD_IDX_W-1:0] word_cnt;
  logic [31:0] keyid;
  logic [KEY_WORDS*32-1:0] key;

  // ------------------------------------------------------------
  // Fetch FSM
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state <= KEY_IDLE;
      word_cnt <= '0;
      keyid <= '0;
    end else begin
      case (state)
        KEY_IDLE: begin
          if (i_start) begin
            state <= KEY_REQUEST;
            keyid <= i_keyid;
          end
        end
        KEY_REQUEST: begin
          if (i_keymem_ready) begin
            state <= KEY_COLLECT;
            word_cnt <= '0;
          end
        end
        KEY_COLLECT: begin
          if (i_keymem_key_valid) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == KEY_WORD_IDX_W'(KEY_WORDS - 1)) begin
              state <= KEY_DONE;
            end
          end else if (i_keymem_ready) begin
            // Memory went idle before the whole key arrived
            state <= KEY_ERROR;
          end
        end
        default: begin
          state <= KEY_IDLE;
        end
      endcase
    end
  end

  // Words may arrive in any order, each lands at its own index
  always_ff @(posedge i_clk) begin
    if (state == KEY_COLLECT && i_keymem_key_valid) begin
      key[i_keymem_key_word*32 +: 32] <= i_keymem_key_data;
    end
  end

  assign o_keymem_get_key_md5 = (state == KEY_REQUEST) && i_keymem_ready;
  assign o_keymem_keyid = keyid;
  assign o_key = key;
  assign o_key_done = (state == KEY_DONE);
  assign o_key_error = (state == KEY_ERROR);

  a_key_word_in_range : assert property (
    @(posedge i_clk) disable iff (i_areset)
    i_keymem_key_valid |-> (i_keymem_key_word < KEY_WORD_IDX_W'(KEY_WORDS))
  );

endmodule

`default_nettype wire

//--- rtl/ntp_field_capture.sv
`timescale 1ns/1ps
`default_nettype none

module ntp_field_capture
  import ntp_auth_pkg::*;
(
  input wire i_clk,
  input wire i_areset,
  input wire i_rx_reset,
  input wire i_payload_valid,
  input wire [RX_WORD_W-1:0] i_payload_data,
  output logic [NTP_HEADER_WORDS*RX_WORD_W-1:0] o_ntp_header,
  output logic [31:0] o_keyid,
  output logic [MAC_W-1:0] o_mac
);

  logic [WORD_CNT_W-1:0] pcnt;
  logic [NTP_HEADER_WORDS-1:0][RX_WORD_W-1:0] header;
  logic [31:0] keyid;
  logic [MAC_W-1:0] mac;
  mac_word_u mac_word;

  assign mac_word = i_payload_data;

  // Saturating payload word counter
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      pcnt <= '0;
    end else if (i_rx_reset) begin
      pcnt <= '0;
    end else if (i_payload_valid && pcnt != '1) begin
      pcnt <= pcnt + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Field steering
  // ------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_payload_valid) begin
      if (pcnt < WORD_CNT_W'(NTP_HEADER_WORDS)) begin
        // Shifting in leaves the first header word at the top
        header <= {header[NTP_HEADER_WORDS-2:0], i_payload_data};
      end else if (pcnt == WORD_CNT_W'(NTP_HEADER_WORDS)) begin
        keyid <= mac_word.half[1];
        mac[127:96] <= mac_word.half[0];
      end else if (pcnt == WORD_CNT_W'(NTP_HEADER_WORDS + 1)) begin
        mac[95:32] <= i_payload_data;
      end else if (pcnt == WORD_CNT_W'(NTP_HEADER_WORDS + 2)) begin
        mac[31:0] <= i_payload_data[63:32];
      end
    end
  end

  assign o_ntp_header = header;
  assign o_keyid = keyid;
  assign o_mac = mac;

endmodule

`default_nettype wire

//--- rtl/udp_payload_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module udp_payload_aligner
  import ntp_auth_pkg::*;
(
  input wire i_clk,
  input wire i_areset,
  input wire i_rx_reset,
  input wire i_rx_valid,
  input wire [RX_WORD_W-1:0] i_rx_data,
  output logic o_payload_valid,
  output logic [RX_WORD_W-1:0] o_payload_data
);

  logic [WORD_CNT_W-1:0] rx_cnt;
  logic ipv4;
  logic in_payload;
  logic carry_valid;
  logic [47:0] carry;
  logic payload_valid;
  logic [RX_WORD_W-1:0] payload_data;

  assign in_payload = ipv4 && (rx_cnt >= WORD_CNT_W'(PAYLOAD_FIRST_WORD));

  // ------------------------------------------------------------
  // Frame word counter and EtherType check
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      rx_cnt <= '0;
      ipv4 <= 1'b0;
      carry_valid <= 1'b0;
      payload_valid <= 1'b0;
    end else if (i_rx_reset) begin
      rx_cnt <= '0;
      ipv4 <= 1'b0;
      carry_valid <= 1'b0;
      payload_valid <= 1'b0;
    end else begin
      if (i_rx_valid && rx_cnt != '1) begin
        rx_cnt <= rx_cnt + 1'b1;
      end
      if (i_rx_valid && rx_cnt == WORD_CNT_W'(1) && i_rx_data[31:16] == ETHERTYPE_IPV4) begin
        ipv4 <= 1'b1;
      end
      // A held carry turns into a word on the next valid word or on the first gap
      carry_valid <= in_payload && i_rx_valid;
      payload_valid <= in_payload && carry_valid;
    end
  end

  // UDP payload starts two bytes into a word, so 48 bits travel to the next one
  always_ff @(posedge i_clk) begin
    if (i_rx_valid) begin
      carry <= i_rx_data[47:0];
      payload_data <= {carry, i_rx_data[63:48]};
    end else begin
      payload_data <= {carry, 16'h0000};
    end
  end

  assign o_payload_valid = payload_valid;
  assign o_payload_data = payload_data;

  a_payload_needs_ipv4 : assert property (
    @(posedge i_clk) disable iff (i_areset) o_payload_valid |-> ipv4
  );

endmodule

`default_nettype wire

//--- rtl/ntp_auth_pkg.sv
`default_nettype none

package ntp_auth_pkg;

  // Receive path
  localparam int RX_WORD_W = 64;
  localparam int WORD_CNT_W = 16;
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam int PAYLOAD_FIRST_WORD = 5;
  localparam int NTP_HEADER_WORDS = 6;

  // Key memory
  localparam int KEY_WORDS = 5;
  localparam int KEY_WORD_IDX_W = 3;

  // MD5 framing
  localparam int MAC_W = 128;
  localparam int MD5_BLOCK_W = 512;
  localparam logic [63:0] MD5_MSG_BITS = 64'd544;
  localparam logic [7:0] MD5_PAD_BYTE = 8'h80;

  // Key fetch FSM encoding
  localparam int KEY_FSM_W = 3;
  localparam logic [KEY_FSM_W-1:0] KEY_IDLE = 3'd0;
  localparam logic [KEY_FSM_W-1:0] KEY_REQUEST = 3'd1;
  localparam logic [KEY_FSM_W-1:0] KEY_COLLECT = 3'd2;
  localparam logic [KEY_FSM_W-1:0] KEY_DONE = 3'd3;
  localparam logic [KEY_FSM_W-1:0] KEY_ERROR = 3'd4;

  // Authentication FSM encoding
  localparam int AUTH_FSM_W = 3;
  localparam logic [AUTH_FSM_W-1:0] AUTH_IDLE = 3'd0;
  localparam logic [AUTH_FSM_W-1:0] AUTH_KEY_WAIT = 3'd1;
  localparam logic [AUTH_FSM_W-1:0] AUTH_INIT = 3'd2;
  localparam logic [AUTH_FSM_W-1:0] AUTH_INIT_WAIT = 3'd3;
  localparam logic [AUTH_FSM_W-1:0] AUTH_NEXT0 = 3'd4;
  localparam logic [AUTH_FSM_W-1:0] AUTH_NEXT0_WAIT = 3'd5;
  localparam logic [AUTH_FSM_W-1:0] AUTH_NEXT1 = 3'd6;
  localparam logic [AUTH_FSM_W-1:0] AUTH_NEXT1_WAIT = 3'd7;

  // Payload word 6 is either raw data or key id (upper) and MAC head (lower)
  typedef union packed {
    logic [RX_WORD_W-1:0] raw;
    logic [1:0][31:0] half;
  } mac_word_u;

endpackage

`default_nettype wire
